/* design/fc_pkg.sv */
// ====================
// flow-control widths, command, class and result types
// credit conversion and command decode functions
// ====================
`default_nettype none

package fc_pkg;

    // default credit counter widths
    parameter int FC_HDR_W  = 12;
    parameter int FC_DATA_W = 16;

    // payload length in dwords
    typedef logic [9:0] fc_len_t;

    // data credits of one packet, at most 256
    typedef logic [8:0] fc_dcred_t;

    typedef enum logic [1:0] {
        FC_P   = 2'd0,
        FC_NP  = 2'd1,
        FC_CPL = 2'd2
    } fc_class_t;

    typedef enum logic [2:0] {
        FC_NONE  = 3'd0,
        FC_P_H   = 3'd1,
        FC_P_D   = 3'd2,
        FC_NP_H  = 3'd3,
        FC_NP_D  = 3'd4,
        FC_CPL_H = 3'd5,
        FC_CPL_D = 3'd6
    } fc_cmd_t;

    typedef enum logic [2:0] {
        FC_INVALID     = 3'd0,
        FC_FAILED      = 3'd1,
        FC_SUCCESS_1   = 3'd2,
        FC_SUCCESS_2   = 3'd3,
        FC_SUCCESS_1_2 = 3'd4
    } fc_result_t;

    // one data credit per started group of four dwords
    function automatic fc_dcred_t fc_data_credits(input fc_len_t len);
        logic [10:0] sum;
        sum = {1'b0, len} + 11'd3;
        return fc_dcred_t'(sum >> 2);
    endfunction

    function automatic fc_class_t fc_cmd_class(input fc_cmd_t cmd);
        case (cmd)
            FC_NP_H, FC_NP_D:   return FC_NP;
            FC_CPL_H, FC_CPL_D: return FC_CPL;
            // none falls here too, callers gate on it
            default:            return FC_P;
        endcase
    endfunction

    function automatic logic fc_cmd_has_data(input fc_cmd_t cmd);
        return (cmd == FC_P_D) || (cmd == FC_NP_D) || (cmd == FC_CPL_D);
    endfunction

endpackage

`default_nettype wire

/* design/fc_class_credit.sv */
// ====================
// credit limit and consumed counters of one traffic class
// ====================
`default_nettype none

module fc_class_credit #(
    parameter fc_pkg::fc_class_t CLASS  = fc_pkg::FC_P,
    parameter int                HDR_W  = 12,
    parameter int                DATA_W = 16
) (
    input  wire logic              clk,
    input  wire logic              arst,
    // limit update from the data link layer
    input  wire logic              fc_upd_valid,
    input  wire fc_pkg::fc_class_t fc_upd_class,
    input  wire logic [HDR_W-1:0]  hdr_limit,
    input  wire logic [DATA_W-1:0] data_limit,
    // charge from the credit arbiter
    input  wire logic [1:0]        consume_hdr,
    input  wire logic [DATA_W-1:0] consume_data,
    output logic [HDR_W-1:0]       hdr_avail,
    output logic [DATA_W-1:0]      data_avail
);

    logic [HDR_W-1:0]  hdr_lim;
    logic [DATA_W-1:0] data_lim;
    logic [HDR_W-1:0]  hdr_used;
    logic [DATA_W-1:0] data_used;
    logic              upd_hit;

    assign upd_hit = fc_upd_valid && (fc_upd_class == CLASS);

    // limits only load for our own class
    always_ff @(posedge clk or negedge arst) begin
        if (!arst) begin
            hdr_lim  <= '0;
            data_lim <= '0;
        end else if (upd_hit) begin
            hdr_lim  <= hdr_limit;
            data_lim <= data_limit;
        end
    end

    // consumed counts, zero amounts when no grant
    always_ff @(posedge clk or negedge arst) begin
        if (!arst) begin
            hdr_used  <= '0;
            data_used <= '0;
        end else begin
            hdr_used  <= hdr_used + {{(HDR_W-2){1'b0}}, consume_hdr};
            data_used <= data_used + consume_data;
        end
    end

    // available credit, clamped at zero
    always_comb begin
        if (hdr_lim > hdr_used) begin
            hdr_avail = hdr_lim - hdr_used;
        end else begin
            hdr_avail = '0;
        end
        if (data_lim > data_used) begin
            data_avail = data_lim - data_used;
        end else begin
            data_avail = '0;
        end
    end

    // arbiter must never charge more than it was shown
    a_consume_fits : assert property (
        @(posedge clk) disable iff (!arst)
        ({{(HDR_W-2){1'b0}}, consume_hdr} <= hdr_avail) && (consume_data <= data_avail)
    ) else $error("class %0d charged beyond available credit", CLASS);

endmodule

`default_nettype wire

/* design/fc_credit_arbiter.sv */
// ====================
// two-slot credit check with per-class consume amounts
// and the registered grant result
// ====================
`default_nettype none

module fc_credit_arbiter #(
    parameter int HDR_W  = 12,
    parameter int DATA_W = 16
) (
    input  wire logic              clk,
    input  wire logic              arst,
    // requests from the transmit arbiter
    input  wire fc_pkg::fc_cmd_t   cmd_1,
    input  wire fc_pkg::fc_len_t   ptlp_1,
    input  wire fc_pkg::fc_cmd_t   cmd_2,
    input  wire fc_pkg::fc_len_t   ptlp_2,
    // availability per class
    input  wire logic [HDR_W-1:0]  hdr_avail_p,
    input  wire logic [DATA_W-1:0] data_avail_p,
    input  wire logic [HDR_W-1:0]  hdr_avail_np,
    input  wire logic [DATA_W-1:0] data_avail_np,
    input  wire logic [HDR_W-1:0]  hdr_avail_cpl,
    input  wire logic [DATA_W-1:0] data_avail_cpl,
    // charge per class
    output logic [1:0]             consume_hdr_p,
    output logic [DATA_W-1:0]      consume_data_p,
    output logic [1:0]             consume_hdr_np,
    output logic [DATA_W-1:0]      consume_data_np,
    output logic [1:0]             consume_hdr_cpl,
    output logic [DATA_W-1:0]      consume_data_cpl,
    output fc_pkg::fc_result_t     result
);

    logic [HDR_W-1:0]   hdr_av  [3];
    logic [DATA_W-1:0]  data_av [3];

    fc_pkg::fc_class_t  cls_1;
    fc_pkg::fc_class_t  cls_2;
    logic               valid_1;
    logic               valid_2;
    logic [DATA_W-1:0]  dcost_1;
    logic [DATA_W-1:0]  dcost_2;

    logic [HDR_W-1:0]   hdr_av_1;
    logic [DATA_W-1:0]  data_av_1;
    logic [HDR_W-1:0]   hdr_av_2;
    logic [DATA_W-1:0]  data_av_2;
    logic               same_class;

    logic               fit_1;
    logic               fit_2;
    logic               grant_1;
    logic               grant_2;

    logic [1:0]         cons_hdr  [3];
    logic [DATA_W-1:0]  cons_data [3];
    fc_pkg::fc_result_t result_nxt;

    // index availability by class encoding
    assign hdr_av[0]  = hdr_avail_p;
    assign hdr_av[1]  = hdr_avail_np;
    assign hdr_av[2]  = hdr_avail_cpl;
    assign data_av[0] = data_avail_p;
    assign data_av[1] = data_avail_np;
    assign data_av[2] = data_avail_cpl;

    // slot decode
    assign valid_1 = (cmd_1 != fc_pkg::FC_NONE);
    assign valid_2 = (cmd_2 != fc_pkg::FC_NONE);
    assign cls_1   = fc_pkg::fc_cmd_class(cmd_1);
    assign cls_2   = fc_pkg::fc_cmd_class(cmd_2);

    always_comb begin
        dcost_1 = '0;
        dcost_2 = '0;
        if (fc_pkg::fc_cmd_has_data(cmd_1)) begin
            dcost_1 = DATA_W'(fc_pkg::fc_data_credits(ptlp_1));
        end
        if (fc_pkg::fc_cmd_has_data(cmd_2)) begin
            dcost_2 = DATA_W'(fc_pkg::fc_data_credits(ptlp_2));
        end
    end

    // slot 1 against its own class
    assign hdr_av_1  = hdr_av[cls_1];
    assign data_av_1 = data_av[cls_1];
    assign fit_1     = valid_1 && (hdr_av_1 != '0) && (data_av_1 >= dcost_1);

    // slot 2 sees what slot 1 leaves behind in a shared class
    assign same_class = fit_1 && (cls_1 == cls_2);

    always_comb begin
        hdr_av_2  = hdr_av[cls_2];
        data_av_2 = data_av[cls_2];
        if (same_class) begin
            hdr_av_2  = hdr_av_2 - {{(HDR_W-1){1'b0}}, 1'b1};
            data_av_2 = data_av_2 - dcost_1;
        end
    end

    assign fit_2 = valid_2 && (hdr_av_2 != '0) && (data_av_2 >= dcost_2);

    // empty slot 1 means no grant at all
    assign grant_1 = fit_1;
    assign grant_2 = valid_1 && fit_2;

    always_comb begin
        cons_hdr  = '{2'd0, 2'd0, 2'd0};
        cons_data = '{'0, '0, '0};
        if (grant_1) begin
            cons_hdr[cls_1]  = cons_hdr[cls_1] + 2'd1;
            cons_data[cls_1] = cons_data[cls_1] + dcost_1;
        end
        if (grant_2) begin
            cons_hdr[cls_2]  = cons_hdr[cls_2] + 2'd1;
            cons_data[cls_2] = cons_data[cls_2] + dcost_2;
        end
    end

    assign consume_hdr_p    = cons_hdr[0];
    assign consume_data_p   = cons_data[0];
    assign consume_hdr_np   = cons_hdr[1];
    assign consume_data_np  = cons_data[1];
    assign consume_hdr_cpl  = cons_hdr[2];
    assign consume_data_cpl = cons_data[2];

    always_comb begin
        if (!valid_1) begin
            result_nxt = fc_pkg::FC_INVALID;
        end else if (grant_1 && grant_2) begin
            result_nxt = fc_pkg::FC_SUCCESS_1_2;
        end else if (grant_1) begin
            result_nxt = fc_pkg::FC_SUCCESS_1;
        end else if (grant_2) begin
            result_nxt = fc_pkg::FC_SUCCESS_2;
        end else begin
            result_nxt = fc_pkg::FC_FAILED;
        end
    end

    always_ff @(posedge clk or negedge arst) begin
        if (!arst) begin
            result <= fc_pkg::FC_INVALID;
        end else begin
            result <= result_nxt;
        end
    end

    // nothing reaches the trackers without a slot 1 command
    a_no_charge_idle : assert property (
        @(posedge clk) disable iff (!arst)
        (cmd_1 == fc_pkg::FC_NONE) |->
            ((consume_hdr_p | consume_hdr_np | consume_hdr_cpl) == 2'd0) &&
            ((consume_data_p | consume_data_np | consume_data_cpl) == '0)
    ) else $error("credit charged with empty slot 1");

    a_no_both_single : assert property (
        @(posedge clk) disable iff (!arst)
        (cmd_2 == fc_pkg::FC_NONE) |=> (result != fc_pkg::FC_SUCCESS_1_2)
    ) else $error("both slots granted with empty slot 2");

endmodule

`default_nettype wire

/* design/tx_fc_gate.sv */
// ====================
// transmit flow-control credit gate top
// three class trackers and the credit arbiter
// ====================
`default_nettype none

module tx_fc_gate #(
    parameter int HDR_W  = fc_pkg::FC_HDR_W,
    parameter int DATA_W = fc_pkg::FC_DATA_W
) (
    input  wire logic              clk,
    input  wire logic              arst,
    // data link layer limit update
    input  wire logic              fc_upd_valid,
    input  wire fc_pkg::fc_class_t fc_upd_class,
    input  wire logic [HDR_W-1:0]  hdr_limit,
    input  wire logic [DATA_W-1:0] data_limit,
    // transmit arbiter request
    input  wire fc_pkg::fc_cmd_t   cmd_1,
    input  wire fc_pkg::fc_len_t   ptlp_1,
    input  wire fc_pkg::fc_cmd_t   cmd_2,
    input  wire fc_pkg::fc_len_t   ptlp_2,
    output fc_pkg::fc_result_t     result
);

    logic [HDR_W-1:0]  hdr_avail_p;
    logic [DATA_W-1:0] data_avail_p;
    logic [HDR_W-1:0]  hdr_avail_np;
    logic [DATA_W-1:0] data_avail_np;
    logic [HDR_W-1:0]  hdr_avail_cpl;
    logic [DATA_W-1:0] data_avail_cpl;

    logic [1:0]        consume_hdr_p;
    logic [DATA_W-1:0] consume_data_p;
    logic [1:0]        consume_hdr_np;
    logic [DATA_W-1:0] consume_data_np;
    logic [1:0]        consume_hdr_cpl;
    logic [DATA_W-1:0] consume_data_cpl;

    fc_class_credit #(
        .CLASS  (fc_pkg::FC_P),
        .HDR_W  (HDR_W),
        .DATA_W (DATA_W)
    ) p_credit_inst (
        .clk          (clk),
        .arst         (arst),
        .fc_upd_valid (fc_upd_valid),
        .fc_upd_class (fc_upd_class),
        .hdr_limit    (hdr_limit),
        .data_limit   (data_limit),
        .consume_hdr  (consume_hdr_p),
        .consume_data (consume_data_p),
        .hdr_avail    (hdr_avail_p),
        .data_avail   (data_avail_p)
    );

    fc_class_credit #(
        .CLASS  (fc_pkg::FC_NP),
        .HDR_W  (HDR_W),
        .DATA_W (DATA_W)
    ) np_credit_inst (
        .clk          (clk),
        .arst         (arst),
        .fc_upd_valid (fc_upd_valid),
        .fc_upd_class (fc_upd_class),
        .hdr_limit    (hdr_limit),
        .data_limit   (data_limit),
        .consume_hdr  (consume_hdr_np),
        .consume_data (consume_data_np),
        .hdr_avail    (hdr_avail_np),
        .data_avail   (data_avail_np)
    );

    fc_class_credit #(
        .CLASS  (fc_pkg::FC_CPL),
        .HDR_W  (HDR_W),
        .DATA_W (DATA_W)
    ) cpl_credit_inst (
        .clk          (clk),
        .arst         (arst),
        .fc_upd_valid (fc_upd_valid),
        .fc_upd_class (fc_upd_class),
        .hdr_limit    (hdr_limit),
        .data_limit   (data_limit),
        .consume_hdr  (consume_hdr_cpl),
        .consume_data (consume_data_cpl),
        .hdr_avail    (hdr_avail_cpl),
        .data_avail   (data_avail_cpl)
    );

    fc_credit_arbiter #(
        .HDR_W  (HDR_W),
        .DATA_W (DATA_W)
    ) arbiter_inst (
        .clk              (clk),
        .arst             (arst),
        .cmd_1            (cmd_1),
        .ptlp_1           (ptlp_1),
        .cmd_2            (cmd_2),
        .ptlp_2           (ptlp_2),
        .hdr_avail_p      (hdr_avail_p),
        .data_avail_p     (data_avail_p),
        .hdr_avail_np     (hdr_avail_np),
        .data_avail_np    (data_avail_np),
        .hdr_avail_cpl    (hdr_avail_cpl),
        .data_avail_cpl   (data_avail_cpl),
        .consume_hdr_p    (consume_hdr_p),
        .consume_data_p   (consume_data_p),
        .consume_hdr_np   (consume_hdr_np),
        .consume_data_np  (consume_data_np),
        .consume_hdr_cpl  (consume_hdr_cpl),
        .consume_data_cpl (consume_data_cpl),
        .result           (result)
    );

endmodule

`default_nettype wire

/* tests/fc_credit_model.svh */
// ====================
// credit model for the gate testbench
// limits, consumed counts and the grant rule
// ====================
`ifndef FC_CREDIT_MODEL_SVH
`define FC_CREDIT_MODEL_SVH

    int lim_hdr   [3];
    int lim_data  [3];
    int used_hdr  [3];
    int used_data [3];

    function automatic logic [1:0] cmd_class_of(input fc_pkg::fc_cmd_t cmd);
        case (cmd)
            fc_pkg::FC_NP_H, fc_pkg::FC_NP_D:   return 2'd1;
            fc_pkg::FC_CPL_H, fc_pkg::FC_CPL_D: return 2'd2;
            default:                            return 2'd0;
        endcase
    endfunction

    function automatic logic carries_data(input fc_pkg::fc_cmd_t cmd);
        return (cmd == fc_pkg::FC_P_D) || (cmd == fc_pkg::FC_NP_D) || (cmd == fc_pkg::FC_CPL_D);
    endfunction

    // availability clamped at zero
    function automatic int hdr_left(input logic [1:0] k);
        return (lim_hdr[k] > used_hdr[k]) ? lim_hdr[k] - used_hdr[k] : 0;
    endfunction

    function automatic int data_left(input logic [1:0] k);
        return (lim_data[k] > used_data[k]) ? lim_data[k] - used_data[k] : 0;
    endfunction

    // expected result of one request, charging the granted slots
    function automatic fc_pkg::fc_result_t predict_grant(input fc_pkg::fc_cmd_t c1, input int l1,
                                                         input fc_pkg::fc_cmd_t c2, input int l2);
        logic [1:0] k1;
        logic [1:0] k2;
        int         d1;
        int         d2;
        int         h_av2;
        int         d_av2;
        logic       fit1;
        logic       fit2;
        if (c1 == fc_pkg::FC_NONE) begin
            return fc_pkg::FC_INVALID;
        end
        k1 = cmd_class_of(c1);
        k2 = cmd_class_of(c2);
        d1 = carries_data(c1) ? (l1 + 3) / 4 : 0;
        d2 = carries_data(c2) ? (l2 + 3) / 4 : 0;
        fit1 = (hdr_left(k1) >= 1) && (data_left(k1) >= d1);
        h_av2 = hdr_left(k2);
        d_av2 = data_left(k2);
        if (fit1 && (k1 == k2)) begin
            h_av2 = h_av2 - 1;
            d_av2 = d_av2 - d1;
        end
        fit2 = (c2 != fc_pkg::FC_NONE) && (h_av2 >= 1) && (d_av2 >= d2);
        if (fit1) begin
            used_hdr[k1]  = used_hdr[k1] + 1;
            used_data[k1] = used_data[k1] + d1;
        end
        if (fit2) begin
            used_hdr[k2]  = used_hdr[k2] + 1;
            used_data[k2] = used_data[k2] + d2;
        end
        if (fit1 && fit2) return fc_pkg::FC_SUCCESS_1_2;
        if (fit1) return fc_pkg::FC_SUCCESS_1;
        if (fit2) return fc_pkg::FC_SUCCESS_2;
        return fc_pkg::FC_FAILED;
    endfunction

    task automatic load_limit(input logic uv, input logic [1:0] k, input int hl, input int dl);
        if (uv) begin
            lim_hdr[k]  = hl;
            lim_data[k] = dl;
        end
    endtask

    task automatic clear_credits();
        lim_hdr   = '{0, 0, 0};
        lim_data  = '{0, 0, 0};
        used_hdr  = '{0, 0, 0};
        used_data = '{0, 0, 0};
    endtask

`endif

/* tests/tx_fc_gate_tb.sv */
// ====================
// testbench for the transmit flow-control credit gate
// random requests checked against a credit model
// ====================
`default_nettype none

module tx_fc_gate_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HDR_W  = fc_pkg::FC_HDR_W;
    localparam int DATA_W = fc_pkg::FC_DATA_W;
    // reset plus the cycles of the six tests
    localparam int TEST_CYCLES = 8 + 16 + 200 + 200 + 13 + 6 + 15;
    localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

    logic               clk;
    logic               arst;
    logic               fc_upd_valid;
    fc_pkg::fc_class_t  fc_upd_class;
    logic [HDR_W-1:0]   hdr_limit;
    logic [DATA_W-1:0]  data_limit;
    fc_pkg::fc_cmd_t    cmd_1;
    fc_pkg::fc_len_t    ptlp_1;
    fc_pkg::fc_cmd_t    cmd_2;
    fc_pkg::fc_len_t    ptlp_2;
    fc_pkg::fc_result_t result;

    int seed;
    int errors;
    int test_errors;
    int checks;
    int tests;
    int cycle_count = 0;

    `include "fc_credit_model.svh"

    tx_fc_gate #(
        .HDR_W  (HDR_W),
        .DATA_W (DATA_W)
    ) tx_fc_gate_inst (
        .clk          (clk),
        .arst         (arst),
        .fc_upd_valid (fc_upd_valid),
        .fc_upd_class (fc_upd_class),
        .hdr_limit    (hdr_limit),
        .data_limit   (data_limit),
        .cmd_1        (cmd_1),
        .ptlp_1       (ptlp_1),
        .cmd_2        (cmd_2),
        .ptlp_2       (ptlp_2),
        .result       (result)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles, the tests did not finish", cycle_count);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        checks = checks + 1;
        if (actual !== expected) begin
            $display("ERR at %0t %s got %0d expected %0d", $time, name, actual, expected);
            test_errors = test_errors + 1;
        end
    endtask

    function automatic int pick_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [1:0] any_class();
        return 2'(pick_below(3));
    endfunction

    function automatic fc_pkg::fc_cmd_t cmd_of(input logic [1:0] cls, input logic data);
        case (cls)
            2'd1:    return data ? fc_pkg::FC_NP_D : fc_pkg::FC_NP_H;
            2'd2:    return data ? fc_pkg::FC_CPL_D : fc_pkg::FC_CPL_H;
            default: return data ? fc_pkg::FC_P_D : fc_pkg::FC_P_H;
        endcase
    endfunction

    function automatic fc_pkg::fc_cmd_t any_cmd();
        return cmd_of(any_class(), pick_below(2) == 1);
    endfunction

    // one request cycle, entered and left at a falling edge
    task automatic run_cycle(input logic uv, input logic [1:0] ucls, input int hl, input int dl,
                             input fc_pkg::fc_cmd_t c1, input int l1,
                             input fc_pkg::fc_cmd_t c2, input int l2);
        fc_pkg::fc_result_t expected;
        fc_upd_valid = uv;
        fc_upd_class = fc_pkg::fc_class_t'(ucls);
        hdr_limit    = HDR_W'(hl);
        data_limit   = DATA_W'(dl);
        cmd_1        = c1;
        ptlp_1       = fc_pkg::fc_len_t'(l1);
        cmd_2        = c2;
        ptlp_2       = fc_pkg::fc_len_t'(l2);
        @(posedge clk);
        // request sees the limits from before this edge
        expected = predict_grant(c1, l1, c2, l2);
        load_limit(uv, ucls, hl, dl);
        @(negedge clk);
        compare_value("result", 32'(result), 32'(expected));
    endtask

    // limits grow in random steps now and then
    task automatic random_request(input fc_pkg::fc_cmd_t c1, input fc_pkg::fc_cmd_t c2);
        logic [1:0] k;
        k = any_class();
        run_cycle(pick_below(4) == 0, k, lim_hdr[k] + pick_below(8), lim_data[k] + pick_below(512),
                  c1, pick_below(1024), c2, pick_below(1024));
    endtask

    task automatic end_test(input string name);
        $display("%s: %0d errors", name, test_errors);
        errors      = errors + test_errors;
        test_errors = 0;
        tests       = tests + 1;
    endtask

    initial begin
        logic [1:0] c;
        logic [1:0] k1;
        logic [1:0] k2;
        int         len;
        seed         = 93695;
        errors       = 0;
        test_errors  = 0;
        checks       = 0;
        tests        = 0;
        arst         = 1'b0;
        fc_upd_valid = 1'b0;
        fc_upd_class = fc_pkg::FC_P;
        hdr_limit    = '0;
        data_limit   = '0;
        cmd_1        = fc_pkg::FC_NONE;
        ptlp_1       = '0;
        cmd_2        = fc_pkg::FC_NONE;
        ptlp_2       = '0;
        clear_credits();
        repeat (8) @(negedge clk);
        arst = 1'b1;

        compare_value("result", 32'(result), 32'(fc_pkg::FC_INVALID));
        repeat (16) run_cycle(1'b0, 2'd0, 0, 0, any_cmd(), pick_below(1024),
                              any_cmd(), pick_below(1024));
        end_test("after reset");

        for (int i = 0; i < 200; i++) begin
            random_request(any_cmd(), fc_pkg::FC_NONE);
        end
        end_test("single slot");

        for (int i = 0; i < 200; i++) begin
            k1 = any_class();
            do k2 = any_class(); while (k2 == k1);
            random_request(cmd_of(k1, pick_below(2) == 1), cmd_of(k2, pick_below(2) == 1));
        end
        end_test("two classes");

        // fresh credits so each class can hold exactly one packet
        arst = 1'b0;
        clear_credits();
        @(negedge clk);
        arst = 1'b1;
        for (c = 2'd0; c != 2'd3; c = c + 2'd1) begin
            len = 1 + pick_below(1023);
            run_cycle(1'b1, c, 1, (len + 3) / 4, fc_pkg::FC_NONE, 0, fc_pkg::FC_NONE, 0);
            run_cycle(1'b0, 2'd0, 0, 0, cmd_of(c, 1'b1), len, cmd_of(c, 1'b0), 0);
            // one more header, data all used
            run_cycle(1'b1, c, 2, (len + 3) / 4, fc_pkg::FC_NONE, 0, fc_pkg::FC_NONE, 0);
            run_cycle(1'b0, 2'd0, 0, 0, cmd_of(c, 1'b1), len, cmd_of(c, 1'b0), 0);
        end
        end_test("same class");

        for (c = 2'd0; c != 2'd3; c = c + 2'd1) begin
            run_cycle(1'b1, c, 3, lim_data[c], cmd_of(c, 1'b0), 0, fc_pkg::FC_NONE, 0);
            run_cycle(1'b0, 2'd0, 0, 0, cmd_of(c, 1'b0), 0, fc_pkg::FC_NONE, 0);
        end
        end_test("update with request");

        for (c = 2'd0; c != 2'd3; c = c + 2'd1) begin
            run_cycle(1'b1, c, 4, lim_data[c], fc_pkg::FC_NONE, 0, fc_pkg::FC_NONE, 0);
            // a header that would fit if slot 2 were charged on its own
            run_cycle(1'b0, 2'd0, 0, 0, fc_pkg::FC_NONE, 0, cmd_of(c, 1'b0), 0);
            repeat (2) run_cycle(1'b0, 2'd0, 0, 0, fc_pkg::FC_NONE, 0, any_cmd(), pick_below(1024));
            run_cycle(1'b0, 2'd0, 0, 0, cmd_of(c, 1'b0), 0, cmd_of(c, 1'b0), 0);
        end
        end_test("empty slot 1");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+tests
design/fc_pkg.sv
design/fc_class_credit.sv
design/fc_credit_arbiter.sv
design/tx_fc_gate.sv
tests/tx_fc_gate_tb.sv

/* Makefile */
# Verilator simulation of the transmit flow-control credit gate

TOP = tx_fc_gate_tb

all: run

obj_dir/V$(TOP): sim.f design/*.sv tests/*.sv tests/*.svh
	verilator --binary --timing --assert --timescale 1ns/1ps -f sim.f \
		--top-module $(TOP) -Mdir obj_dir

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation completed successfully" sim.log

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps -f sim.f \
		--top-module tx_fc_gate

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean
